/* hdl/heap_pkg.sv */
// heap sizes, collection thresholds, slot widths, colour codes and collector states
package heap_pkg;

	localparam int HEAP_SLOTS = 32;
	localparam int SLOT_BITS = 8; // payload bits behind one slot
	localparam int MAX_BLOCK = 4;
	localparam int ROOT_DEPTH = 16;

	// 70 percent of the heap, rounded down
	localparam int GC_THRESHOLD = (HEAP_SLOTS * 7) / 10;
	localparam int GC_DEPTH = 10; // mark passes before the sweep is forced

	typedef logic [4:0] slot_idx_t;
	typedef logic [5:0] slot_cnt_t; // 0 up to HEAP_SLOTS inclusive
	typedef logic [2:0] blk_len_t;
	typedef logic [5:0] bit_len_t;
	typedef logic [3:0] root_idx_t;
	typedef logic [1:0] colour_t;

	localparam colour_t COLOUR_WHITE = 2'b00;
	localparam colour_t COLOUR_GREY = 2'b01;
	localparam colour_t COLOUR_BLACK = 2'b11;

	typedef enum logic [1:0]
	{
		GC_IDLE,
		GC_ROOTS,
		GC_MARK,
		GC_SWEEP
	} gc_state_t;

endpackage

/* hdl/heap_alloc.sv */
// first-fit block placement and rounding of bit lengths to whole slots
`timescale 1ns/1ps

module heap_alloc
	import heap_pkg::*;
(
	input  logic gc,
	input  logic rst,
	input  logic alloc_req,
	input  bit_len_t alloc_bits,
	input  logic alloc_root,
	input  logic alloc_refer,
	input  slot_idx_t alloc_ref_slot,
	input  logic gc_active,
	input  logic [HEAP_SLOTS-1:0] slot_used,
	output logic alloc_ready,
	output logic alloc_done,
	output logic alloc_ok,
	output slot_idx_t alloc_slot,
	output logic alloc_we,
	output slot_idx_t wr_base,
	output blk_len_t wr_len,
	output logic wr_root,
	output logic wr_refer,
	output slot_idx_t wr_child
);

	blk_len_t need_len;
	blk_len_t div_len;
	logic accept;
	logic fit_ok;
	logic run_free;
	slot_idx_t fit_base;

	assign alloc_ready = !gc_active;
	assign accept = alloc_req && alloc_ready;

	// round up to whole slots, a zero length still takes one slot
	assign div_len = blk_len_t'((alloc_bits + bit_len_t'(SLOT_BITS - 1)) / SLOT_BITS);
	assign need_len = (div_len == '0) ? blk_len_t'(1) : div_len;

	// scanning from the top down leaves the lowest fitting base in fit_base
	always_comb
	begin
		fit_ok = 1'b0;
		fit_base = '0;
		run_free = 1'b0;
		for (int b = HEAP_SLOTS - 1; b >= 0; b--)
		begin
			run_free = 1'b1;
			for (int k = 0; k < MAX_BLOCK; k++)
			begin
				if (k < int'(need_len))
				begin
					if (b + k >= HEAP_SLOTS)
						run_free = 1'b0; // block would run off the end of the heap
					else if (slot_used[b + k])
						run_free = 1'b0;
				end
			end
			if (run_free)
			begin
				fit_ok = 1'b1;
				fit_base = slot_idx_t'(b);
			end
		end
	end

	// the store takes the block on the same edge that raises alloc_done
	assign alloc_we = accept && fit_ok;
	assign wr_base = fit_base;
	assign wr_len = need_len;
	assign wr_root = alloc_root;
	assign wr_refer = alloc_refer;
	assign wr_child = alloc_ref_slot;

	always_ff @(posedge gc)
	begin
		if (rst)
			alloc_done <= 1'b0;
		else
			alloc_done <= accept;
	end

	always_ff @(posedge gc)
	begin
		if (accept)
		begin
			alloc_ok <= fit_ok;
			alloc_slot <= fit_base;
		end
	end

	// a placed block lies inside the heap and covers only slots that were free
	a_fit_free: assert property (@(posedge gc) disable iff (rst)
		alloc_we |-> ((int'(wr_base) + int'(wr_len) <= HEAP_SLOTS) &&
		(((slot_used >> wr_base) & ~({HEAP_SLOTS{1'b1}} << wr_len)) == '0)))
		else $error("block placed over used slots or past the end of the heap");

endmodule

/* hdl/heap_store.sv */
// slot header array, root stack, live slot count and the allocator and collector write ports
`timescale 1ns/1ps

module heap_store
	import heap_pkg::*;
(
	input  logic gc,
	input  logic rst,
	input  logic alloc_we,
	input  slot_idx_t wr_base,
	input  blk_len_t wr_len,
	input  logic wr_root,
	input  logic wr_refer,
	input  slot_idx_t wr_child,
	input  slot_idx_t gc_addr,
	input  logic gc_colour_we,
	input  colour_t gc_colour,
	input  logic gc_free_we,
	input  root_idx_t root_rd,
	output logic [HEAP_SLOTS-1:0] slot_used,
	output slot_cnt_t live_count,
	output logic rd_used,
	output logic rd_head,
	output colour_t rd_colour,
	output blk_len_t rd_len,
	output logic rd_refer,
	output slot_idx_t rd_child,
	output slot_idx_t root_slot,
	output slot_cnt_t root_count
);

	logic [HEAP_SLOTS-1:0] used;
	logic [HEAP_SLOTS-1:0] head;
	logic [HEAP_SLOTS-1:0] refer;
	colour_t colour [HEAP_SLOTS];
	blk_len_t len [HEAP_SLOTS];
	slot_idx_t child [HEAP_SLOTS];
	slot_idx_t root_stack [ROOT_DEPTH];
	logic root_room;

	assign root_room = root_count < slot_cnt_t'(ROOT_DEPTH);

	always_ff @(posedge gc)
	begin
		if (rst)
		begin
			used <= '0;
			live_count <= '0;
			root_count <= '0;
		end
		else if (alloc_we)
		begin
			for (int k = 0; k < MAX_BLOCK; k++)
			begin
				if (k < int'(wr_len))
					used[wr_base + slot_idx_t'(k)] <= 1'b1;
			end
			live_count <= live_count + slot_cnt_t'(wr_len);
			if (wr_root && root_room)
				root_count <= root_count + 1'b1;
		end
		else if (gc_free_we)
		begin
			used[gc_addr] <= 1'b0; // one slot per free strobe
			live_count <= live_count - 1'b1;
		end
	end

	// every slot of a block carries the full header, only the first is flagged as head
	always_ff @(posedge gc)
	begin
		if (alloc_we)
		begin
			for (int k = 0; k < MAX_BLOCK; k++)
			begin
				if (k < int'(wr_len))
				begin
					head[wr_base + slot_idx_t'(k)] <= (k == 0);
					colour[wr_base + slot_idx_t'(k)] <= COLOUR_WHITE;
					len[wr_base + slot_idx_t'(k)] <= wr_len;
					refer[wr_base + slot_idx_t'(k)] <= wr_refer;
					child[wr_base + slot_idx_t'(k)] <= wr_child;
				end
			end
			if (wr_root && root_room)
				root_stack[root_idx_t'(root_count)] <= wr_base;
		end
		else if (gc_colour_we)
			colour[gc_addr] <= gc_colour;
	end

	assign slot_used = used;
	assign rd_used = used[gc_addr];
	assign rd_head = head[gc_addr];
	assign rd_colour = colour[gc_addr];
	assign rd_len = len[gc_addr];
	assign rd_refer = refer[gc_addr];
	assign rd_child = child[gc_addr];
	assign root_slot = root_stack[root_rd];

	// allocator and collector take turns on the store
	a_one_writer: assert property (@(posedge gc) disable iff (rst)
		!(alloc_we && (gc_colour_we || gc_free_we)))
		else $error("allocator and collector wrote the store in the same cycle");

	a_root_room: assert property (@(posedge gc) disable iff (rst)
		(alloc_we && wr_root) |-> root_room)
		else $error("rooted block dropped, root stack full");

endmodule

/* hdl/gc_collector.sv */
// occupancy trigger and the root, mark and sweep FSM of the tricolour collector
`timescale 1ns/1ps

module gc_collector
	import heap_pkg::*;
(
	input  logic gc,
	input  logic rst,
	input  slot_cnt_t live_count,
	input  logic rd_used,
	input  logic rd_head,
	input  colour_t rd_colour,
	input  blk_len_t rd_len,
	input  logic rd_refer,
	input  slot_idx_t rd_child,
	input  slot_idx_t root_slot,
	input  slot_cnt_t root_count,
	output logic gc_active,
	output logic gc_done,
	output slot_idx_t gc_addr,
	output logic gc_colour_we,
	output colour_t gc_colour,
	output logic gc_free_we,
	output root_idx_t root_rd
);

	gc_state_t state;
	slot_idx_t scan;
	root_idx_t rt_idx;
	logic [3:0] pass_cnt;
	slot_cnt_t pass_greys;
	blk_len_t free_left; // follower slots of the block being freed
	logic armed;
	logic [HEAP_SLOTS-1:0] pend_grey;
	logic start;
	logic last_slot;
	logic mark_hit;
	logic sweep_head_free;
	logic sweep_tail_free;
	logic sweep_whiten;

	// rearms only once occupancy has fallen below the threshold again
	assign start = (state == GC_IDLE) && armed && (live_count >= slot_cnt_t'(GC_THRESHOLD));
	assign gc_active = (state != GC_IDLE);
	assign root_rd = rt_idx;
	assign last_slot = (scan == slot_idx_t'(HEAP_SLOTS - 1));
	assign gc_addr = (state == GC_ROOTS) ? root_slot : scan;

	// children wait in pend_grey until the scan reaches them, which saves a second read
	assign mark_hit = (state == GC_MARK) && rd_used && rd_head &&
		((rd_colour == COLOUR_GREY) || ((rd_colour == COLOUR_WHITE) && pend_grey[scan]));

	assign sweep_head_free = (state == GC_SWEEP) && rd_used && rd_head &&
		(rd_colour == COLOUR_WHITE);
	assign sweep_tail_free = (state == GC_SWEEP) && rd_used && !rd_head && (free_left != '0);
	assign sweep_whiten = (state == GC_SWEEP) && rd_used && rd_head &&
		(rd_colour == COLOUR_BLACK);

	assign gc_free_we = sweep_head_free || sweep_tail_free;
	assign gc_colour_we = ((state == GC_ROOTS) && (root_count != '0)) || mark_hit || sweep_whiten;

	always_comb
	begin
		case (state)
			GC_ROOTS: gc_colour = COLOUR_GREY;
			GC_MARK: gc_colour = COLOUR_BLACK;
			default: gc_colour = COLOUR_WHITE;
		endcase
	end

	always_ff @(posedge gc)
	begin
		if (rst)
		begin
			state <= GC_IDLE;
			gc_done <= 1'b0;
			armed <= 1'b1;
			scan <= '0;
			rt_idx <= '0;
			pass_cnt <= '0;
			pass_greys <= '0;
			free_left <= '0;
			pend_grey <= '0;
		end
		else
		begin
			gc_done <= 1'b0;
			if (live_count < slot_cnt_t'(GC_THRESHOLD))
				armed <= 1'b1;
			case (state)
				GC_IDLE:
				begin
					if (start)
					begin
						armed <= 1'b0;
						state <= GC_ROOTS;
						rt_idx <= '0;
						scan <= '0;
						pass_cnt <= '0;
						pass_greys <= '0;
						pend_grey <= '0;
					end
				end
				GC_ROOTS:
				begin
					// one root per cycle
					if ((root_count == '0) || (slot_cnt_t'(rt_idx) + 1'b1 >= root_count))
						state <= GC_MARK;
					else
						rt_idx <= rt_idx + 1'b1;
				end
				GC_MARK:
				begin
					pend_grey[scan] <= 1'b0;
					if (mark_hit)
					begin
						pass_greys <= pass_greys + 1'b1;
						if (rd_refer)
							pend_grey[rd_child] <= 1'b1; // greys the child
					end
					scan <= scan + 1'b1;
					if (last_slot)
					begin
						pass_greys <= '0;
						if (((pass_greys == '0) && !mark_hit) || (pass_cnt == 4'(GC_DEPTH - 1)))
						begin
							state <= GC_SWEEP;
							free_left <= '0;
						end
						else
							pass_cnt <= pass_cnt + 1'b1;
					end
				end
				GC_SWEEP:
				begin
					if (sweep_head_free)
						free_left <= rd_len - 1'b1;
					else if (sweep_tail_free)
						free_left <= free_left - 1'b1;
					else if (rd_used && rd_head)
						free_left <= '0; // a live block starts here
					scan <= scan + 1'b1;
					if (last_slot)
					begin
						state <= GC_IDLE;
						gc_done <= 1'b1;
					end
				end
				default: state <= GC_IDLE;
			endcase
		end
	end

	// a white head still waiting in pend_grey is reachable and would be freed by the sweep
	a_no_grey_left: assert property (@(posedge gc) disable iff (rst)
		((state == GC_SWEEP) && rd_used && rd_head) |->
		((rd_colour != COLOUR_GREY) && !((rd_colour == COLOUR_WHITE) && pend_grey[scan])))
		else $error("grey head left over at sweep, slot %0d", scan);

endmodule

/* hdl/gc_heap_top.sv */
// top level joining the allocator, the heap store and the collector
`timescale 1ns/1ps

module gc_heap_top
	import heap_pkg::*;
(
	input  logic gc,
	input  logic rst,
	input  logic alloc_req,
	input  bit_len_t alloc_bits,
	input  logic alloc_root,
	input  logic alloc_refer,
	input  slot_idx_t alloc_ref_slot,
	output logic alloc_ready,
	output logic alloc_done,
	output logic alloc_ok,
	output slot_idx_t alloc_slot,
	output slot_cnt_t live_count,
	output logic gc_active,
	output logic gc_done
);

	logic alloc_we;
	slot_idx_t wr_base;
	blk_len_t wr_len;
	logic wr_root;
	logic wr_refer;
	slot_idx_t wr_child;
	logic [HEAP_SLOTS-1:0] slot_used;
	slot_idx_t gc_addr;
	logic gc_colour_we;
	colour_t gc_colour;
	logic gc_free_we;
	root_idx_t root_rd;
	logic rd_used;
	logic rd_head;
	colour_t rd_colour;
	blk_len_t rd_len;
	logic rd_refer;
	slot_idx_t rd_child;
	slot_idx_t root_slot;
	slot_cnt_t root_count;

	heap_alloc alloc0 (
		.gc(gc), .rst(rst), .alloc_req(alloc_req), .alloc_bits(alloc_bits),
		.alloc_root(alloc_root), .alloc_refer(alloc_refer), .alloc_ref_slot(alloc_ref_slot),
		.gc_active(gc_active), .slot_used(slot_used), .alloc_ready(alloc_ready),
		.alloc_done(alloc_done), .alloc_ok(alloc_ok), .alloc_slot(alloc_slot),
		.alloc_we(alloc_we), .wr_base(wr_base), .wr_len(wr_len), .wr_root(wr_root),
		.wr_refer(wr_refer), .wr_child(wr_child)
	);

	heap_store store0 (
		.gc(gc), .rst(rst), .alloc_we(alloc_we), .wr_base(wr_base), .wr_len(wr_len),
		.wr_root(wr_root), .wr_refer(wr_refer), .wr_child(wr_child), .gc_addr(gc_addr),
		.gc_colour_we(gc_colour_we), .gc_colour(gc_colour), .gc_free_we(gc_free_we),
		.root_rd(root_rd), .slot_used(slot_used), .live_count(live_count),
		.rd_used(rd_used), .rd_head(rd_head), .rd_colour(rd_colour), .rd_len(rd_len),
		.rd_refer(rd_refer), .rd_child(rd_child), .root_slot(root_slot),
		.root_count(root_count)
	);

	gc_collector coll0 (
		.gc(gc), .rst(rst), .live_count(live_count), .rd_used(rd_used), .rd_head(rd_head),
		.rd_colour(rd_colour), .rd_len(rd_len), .rd_refer(rd_refer), .rd_child(rd_child),
		.root_slot(root_slot), .root_count(root_count), .gc_active(gc_active),
		.gc_done(gc_done), .gc_addr(gc_addr), .gc_colour_we(gc_colour_we),
		.gc_colour(gc_colour), .gc_free_we(gc_free_we), .root_rd(root_rd)
	);

endmodule

/* verification/heap_model.svh */
// heap model state with first-fit placement, reachability from roots and slot occupancy
`ifndef HEAP_MODEL_SVH
`define HEAP_MODEL_SVH

bit m_used [HEAP_SLOTS];
int m_len [HEAP_SLOTS]; // block length at a head slot, 0 on followers and free slots
int m_child [HEAP_SLOTS]; // head of the referenced block, -1 for none
bit m_root [HEAP_SLOTS];
int m_live;
int m_roots;
bit m_armed;

function automatic void model_reset();
	for (int s = 0; s < HEAP_SLOTS; s++)
	begin
		m_used[s] = 1'b0;
		m_len[s] = 0;
		m_child[s] = -1;
		m_root[s] = 1'b0;
	end
	m_live = 0;
	m_roots = 0;
	m_armed = 1'b1;
endfunction

// a request of 1 to 32 bits needs 1 to 4 slots
function automatic int slots_for(input int bits);
	return (bits + SLOT_BITS - 1) / SLOT_BITS;
endfunction

// the first run of n free slots met from slot 0 upward gives the lowest base
function automatic int first_fit(input int n);
	int run;
	run = 0;
	for (int s = 0; s < HEAP_SLOTS; s++)
	begin
		run = m_used[s] ? 0 : run + 1;
		if (run == n)
			return s - n + 1;
	end
	return -1;
endfunction

function automatic void place(input int base, input int n, input bit root, input int child);
	for (int k = 0; k < n; k++)
		m_used[base + k] = 1'b1;
	m_len[base] = n;
	m_child[base] = child;
	m_root[base] = root;
	m_live += n;
	if (root)
		m_roots++;
endfunction

// marks everything reachable from the roots, then frees the rest block by block
function automatic void collect();
	bit reach [HEAP_SLOTS];
	for (int s = 0; s < HEAP_SLOTS; s++)
		reach[s] = m_used[s] && (m_len[s] != 0) && m_root[s];
	for (int p = 0; p < HEAP_SLOTS; p++)
	begin
		for (int s = 0; s < HEAP_SLOTS; s++)
		begin
			if (reach[s] && (m_child[s] >= 0))
				reach[m_child[s]] = 1'b1;
		end
	end
	for (int s = 0; s < HEAP_SLOTS; s++)
	begin
		if (m_used[s] && (m_len[s] != 0) && !reach[s])
		begin
			for (int k = 0; k < m_len[s]; k++)
				m_used[s + k] = 1'b0;
			m_live -= m_len[s];
			m_len[s] = 0;
			m_child[s] = -1;
		end
	end
	m_armed = (m_live < GC_THRESHOLD);
endfunction

`endif

/* verification/tb_gc_heap.sv */
// testbench for the heap allocator and collector with model, assertions, test report and timeout
`timescale 1ns/1ps

module tb_gc_heap
	import heap_pkg::*;
();

	localparam int GC_WORST = ROOT_DEPTH + GC_DEPTH * HEAP_SLOTS + HEAP_SLOTS + 4;
	localparam int MAX_REQS = 66; // 6 + 20 + 24 + 16 requests over the tests
	localparam int CYCLE_LIMIT = 16 + 4 * MAX_REQS + 4 * GC_WORST + 50;

	logic gc;
	logic rst;
	logic alloc_req;
	bit_len_t alloc_bits;
	logic alloc_root;
	logic alloc_refer;
	slot_idx_t alloc_ref_slot;
	logic alloc_ready;
	logic alloc_done;
	logic alloc_ok;
	slot_idx_t alloc_slot;
	slot_cnt_t live_count;
	logic gc_active;
	logic gc_done;

	logic chk_reset;
	logic exp_ok;
	slot_idx_t exp_slot;
	slot_cnt_t exp_live;
	logic exp_trigger;
	int errors;
	int test_err0;
	int tests_run;
	int tests_failed;
	int cycles;
	int gc_count;
	int prev_head; // head of the last block placed, a target for the next child reference
	int start_gc;
	integer seed;

	`include "heap_model.svh"

	gc_heap_top dut0 (
		.gc(gc), .rst(rst), .alloc_req(alloc_req), .alloc_bits(alloc_bits),
		.alloc_root(alloc_root), .alloc_refer(alloc_refer), .alloc_ref_slot(alloc_ref_slot),
		.alloc_ready(alloc_ready), .alloc_done(alloc_done), .alloc_ok(alloc_ok),
		.alloc_slot(alloc_slot), .live_count(live_count), .gc_active(gc_active),
		.gc_done(gc_done)
	);

	always #50 gc = ~gc;

	always @(posedge gc)
		cycles = cycles + 1;

	function automatic void report_mismatch(input string msg);
		errors++;
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
	endfunction

	function automatic int rand_bits();
		return ($unsigned($random(seed)) % 32) + 1;
	endfunction

	a_reset_state: assert property (@(posedge gc)
		chk_reset |-> (!alloc_done && !gc_active && !gc_done && alloc_ready && live_count == '0))
		else report_mismatch("outputs not at their reset values");

	a_done_follows: assert property (@(posedge gc) disable iff (rst)
		(alloc_req && alloc_ready) |=> alloc_done)
		else report_mismatch("no alloc_done one cycle after an accepted request");

	a_alloc_result: assert property (@(posedge gc) disable iff (rst)
		alloc_done |-> (alloc_ok == exp_ok && (!exp_ok || alloc_slot == exp_slot) &&
		live_count == exp_live))
		else report_mismatch($sformatf("alloc ok %0b slot %0d live %0d, expected %0b %0d %0d",
			alloc_ok, alloc_slot, live_count, exp_ok, exp_slot, exp_live));

	a_gc_start: assert property (@(posedge gc) disable iff (rst)
		(alloc_done && exp_trigger) |=> gc_active)
		else report_mismatch("collection did not start after reaching the threshold");

	a_gc_quiet: assert property (@(posedge gc) disable iff (rst)
		(alloc_done && !exp_trigger) |=> !gc_active)
		else report_mismatch("collection started below the threshold");

	a_ready_low: assert property (@(posedge gc) disable iff (rst)
		gc_active |-> !alloc_ready)
		else report_mismatch("alloc_ready high during a collection");

	a_gc_result: assert property (@(posedge gc) disable iff (rst)
		gc_done |-> (!gc_active && live_count == exp_live))
		else report_mismatch($sformatf("live %0d after collection, expected %0d",
			live_count, exp_live));

	// called on the falling edge that follows the triggering allocation
	task automatic run_collection();
		int waited;
		waited = 0;
		while (!gc_active && waited < 4)
		begin
			waited++;
			@(negedge gc);
		end
		collect();
		exp_live = slot_cnt_t'(m_live);
		prev_head = -1;
		gc_count++;
		waited = 0;
		while (!gc_done && waited < GC_WORST)
		begin
			waited++;
			@(negedge gc);
		end
		if (!gc_done)
		begin
			errors++;
			$display("collection did not finish within %0d cycles", GC_WORST);
		end
	endtask

	task automatic do_alloc(input int bits, input bit root, input int child);
		int n;
		int base;
		int waited;
		n = slots_for(bits);
		waited = 0;
		@(negedge gc);
		while (!alloc_ready)
			@(negedge gc);
		base = first_fit(n);
		exp_ok = (base >= 0);
		exp_slot = slot_idx_t'((base >= 0) ? base : 0);
		if (base >= 0)
			place(base, n, root, child);
		exp_live = slot_cnt_t'(m_live);
		exp_trigger = m_armed && (m_live >= GC_THRESHOLD);
		prev_head = base; // -1 after a failed fit
		alloc_bits = bit_len_t'(bits);
		alloc_root = root;
		alloc_refer = (child >= 0);
		alloc_ref_slot = slot_idx_t'((child >= 0) ? child : 0);
		alloc_req = 1'b1;
		@(negedge gc);
		alloc_req = 1'b0;
		while (!alloc_done && waited < 4)
		begin
			waited++;
			@(negedge gc);
		end
		if (!alloc_done)
		begin
			errors++;
			$display("allocation request got no alloc_done");
		end
		if (exp_trigger)
		begin
			m_armed = 1'b0;
			run_collection();
		end
	endtask

	// triples of a plain block, a block pointing at it and a root pointing at that one
	task automatic pattern_alloc(input int i, input bit below);
		int bits;
		int child;
		bits = rand_bits();
		child = (i % 3 != 0) ? prev_head : -1;
		if (!below || (m_live + slots_for(bits) < GC_THRESHOLD))
			do_alloc(bits, (i % 3 == 2), child);
	endtask

	task automatic finish_test(input string name);
		repeat (3) @(negedge gc); // lets the last checks fire
		tests_run++;
		if (errors != test_err0)
		begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - test_err0);
		end
		else
			$display("test %0d %s: ok", tests_run, name);
		test_err0 = errors;
	endtask

	initial
	begin
		wait (cycles >= CYCLE_LIMIT);
		$display("timeout, the run did not end within %0d cycles", cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin
		gc = 1'b0;
		rst = 1'b1;
		alloc_req = 1'b0;
		alloc_bits = bit_len_t'(1);
		alloc_root = 1'b0;
		alloc_refer = 1'b0;
		alloc_ref_slot = '0;
		chk_reset = 1'b0;
		exp_ok = 1'b0;
		exp_slot = '0;
		exp_live = '0;
		exp_trigger = 1'b0;
		errors = 0;
		test_err0 = 0;
		tests_run = 0;
		tests_failed = 0;
		gc_count = 0;
		prev_head = -1;
		seed = 32'he9ba;
		model_reset();
		repeat (16) @(posedge gc);
		@(negedge gc);
		rst = 1'b0;
		chk_reset = 1'b1;
		@(negedge gc);
		chk_reset = 1'b0;
		finish_test("outputs after reset");

		for (int i = 0; i < 6; i++)
			pattern_alloc(i, 1'b1);
		finish_test("first fit of random lengths");

		for (int i = 6; i < 26 && gc_count == 0; i++)
			pattern_alloc(i, 1'b0);
		if (gc_count == 0)
		begin
			errors++;
			$display("the heap never reached the collection threshold");
		end
		finish_test("collection at 70 percent occupancy");

		start_gc = gc_count;
		for (int i = 0; i < 24 && gc_count == start_gc; i++)
			do_alloc(rand_bits(), 1'b0, -1);
		finish_test("refill of freed holes");

		// rooted blocks survive every collection, so the heap ends up full
		for (int i = 0; i < 16 && m_roots < ROOT_DEPTH; i++)
		begin
			do_alloc(32, 1'b1, -1);
			if (!exp_ok)
				break;
		end
		if (exp_ok)
		begin
			errors++;
			$display("no request was refused on a full heap");
		end
		finish_test("failed fit on a full heap");

		$display("%0d tests, %0d with errors, %0d errors in all", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* build.f */
+incdir+verification
hdl/heap_pkg.sv
hdl/heap_alloc.sv
hdl/heap_store.sv
hdl/gc_collector.sv
hdl/gc_heap_top.sv
verification/tb_gc_heap.sv

/* Makefile */
SRCS = build.f $(wildcard hdl/*.sv) $(wildcard verification/*.sv verification/*.svh)

obj_dir/Vtb_gc_heap: $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_gc_heap

run: obj_dir/Vtb_gc_heap
	./obj_dir/Vtb_gc_heap | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
